// ==== cart_mapper_top.f ====
+incdir+tb
hw/cart_pkg.sv
hw/cpu_write_decoder.sv
hw/bank_register_file.sv
hw/address_mapper.sv
hw/cart_mapper_top.sv
tb/cart_mapper_assert.sv
tb/cart_mapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cart_mapper_tb \
	-f cart_mapper_top.f \
	-o cart_mapper_sim

./obj_dir/cart_mapper_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== tb/cart_mapper_tasks.svh ====
// Reference PRG address from the shadow registers
function automatic logic [26:13] expected_cpu_addr(input logic [14:0] a);
	logic [5:0] bank;
	logic [12:0] hi;
	if (exp_mapper == 5'd16)
	begin
		case (exp_r1[3:2])
			2'b10: bank = a[14] ? {1'b0, exp_r4[3:0], a[13]} : {5'b00000, a[13]};
			2'b11: bank = a[14] ? {5'b01111, a[13]} : {1'b0, exp_r4[3:0], a[13]};
			default: bank = {1'b0, exp_r4[3:1], a[14:13]};  // 32 KiB
		endcase
	end
	else if (exp_mapper[3])
		bank = {exp_r1[3:0], a[14:13]};                    // AxROM-like
	else
		bank = {a[14] ? 5'h1f : exp_r1[4:0], a[13]};       // UxROM-like
	hi = exp_base | {8'b0, bank[5:1] & ~exp_mask};
	return {hi, bank[0]};
endfunction

function automatic logic [17:10] expected_chr_addr(input logic [13:0] p);
	logic [7:0] bank;
	if (exp_mapper != 5'd16)
		bank = {exp_r0[4:0], p[12:10]};
	else if (!exp_r1[4])
		bank = {1'b0, exp_r2[4:1], p[12:10]};                // 8 KiB mode
	else
		bank = {1'b0, p[12] ? exp_r3[4:0] : exp_r2[4:0], p[11:10]};
	return {bank[7:3] & ~exp_chr_mask, bank[2:0]};
endfunction

function automatic logic expected_a10(input logic [13:0] p);
	case (exp_mirror)
		2'd0: return p[10];                                  // Vertical
		2'd1: return p[11];                                  // Horizontal
		2'd2: return 1'b0;
		default: return 1'b1;
	endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] expected);
	checks++;
	if (got !== expected)
	begin
		errors++;
		$display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, expected);
	end
endtask

// One write cycle, one read cycle, then one cycle for the register file
task automatic bus_write(input logic [14:0] a, input logic rs, input logic [7:0] d);
	@(posedge m2);
	#1;
	romsel = rs;
	cpu_rw = 1'b0;
	cpu_addr = a;
	cpu_data = d;
	@(posedge m2);
	#1;
	romsel = 1'b1;
	cpu_rw = 1'b1;
	cpu_addr = 15'h0000;
	@(posedge m2);
	@(posedge m2);                                         // Register updated here
endtask

task automatic cfg_write(input logic [2:0] reg_addr, input logic [7:0] d);
	bus_write(15'h5000 | {12'h000, reg_addr}, 1'b1, d);
endtask

// Five serial writes LSB first
task automatic mmc1_load(input logic [14:0] a, input logic [4:0] v);
	for (int i = 0; i < 5; i++)
		bus_write(a, 1'b0, {7'b0, v[i]});
endtask

task automatic check_prg(input logic [14:0] a);
	@(posedge m2);
	#1;
	romsel = 1'b0;
	cpu_rw = 1'b1;
	cpu_addr = a;
	#1;
	check_value("cpu_addr_out", cpu_addr_out, expected_cpu_addr(a));
endtask

task automatic check_ppu(input logic [13:0] p);
	@(posedge m2);
	#1;
	ppu_addr = p;
	#1;
	if (!p[13])
		check_value("ppu_addr_out", ppu_addr_out, expected_chr_addr(p));
	check_value("ppu_ciram_a10", ppu_ciram_a10, expected_a10(p));
endtask

// ROM write, SRAM write, then ROM read with all write enables equal to en
task automatic check_strobes(input logic en);
	@(posedge m2);
	#1;
	romsel = 1'b0;
	cpu_rw = 1'b0;
	cpu_addr = 15'h0000;
	ppu_rd = 1'b0;
	ppu_wr = 1'b0;
	ppu_addr = 14'h0000;
	#1;
	check_value("flash_we", flash_we, !en);
	check_value("flash_oe", flash_oe, 1'b1);
	check_value("sram_ce", sram_ce, 1'b1);
	check_value("sram_we", sram_we, 1'b0);
	check_value("sram_oe", sram_oe, 1'b1);
	check_value("ppu_rd_out", ppu_rd_out, 1'b0);
	check_value("ppu_wr_out", ppu_wr_out, !en);
	@(posedge m2);
	#1;
	romsel = 1'b1;
	cpu_addr = 15'h6000;                                   // $6000 window
	ppu_addr = 14'h2000;                                   // Nametable
	#1;
	check_value("sram_ce", sram_ce, !en);
	check_value("flash_we", flash_we, 1'b1);
	check_value("ppu_rd_out", ppu_rd_out, 1'b1);
	check_value("ppu_wr_out", ppu_wr_out, 1'b1);
	@(posedge m2);
	#1;
	romsel = 1'b0;
	cpu_rw = 1'b1;
	cpu_addr = 15'h0000;
	ppu_rd = 1'b1;
	ppu_wr = 1'b1;
	ppu_addr = 14'h0000;
	#1;
	check_value("flash_oe", flash_oe, 1'b0);
	check_value("flash_we", flash_we, 1'b1);
	check_value("sram_ce", sram_ce, 1'b1);
	check_value("sram_we", sram_we, 1'b1);
	check_value("sram_oe", sram_oe, 1'b0);
endtask

task automatic test_reset();
	apply_reset();
	check_prg(15'h0000);
	check_prg(15'h6000);
	check_strobes(1'b0);                                   // Writes off after reset
endtask

task automatic test_config();
	apply_reset();
	cfg_write(3'd0, 8'h01);
	cfg_write(3'd1, 8'h23);
	exp_base = 13'h0123;
	cfg_write(3'd2, 8'h03);
	exp_mask = 5'h03;
	cfg_write(3'd3, 8'h0b);
	exp_r0 = 8'h0b;
	cfg_write(3'd4, 8'h02);
	exp_chr_mask = 5'h02;
	check_prg(15'h0000);
	check_prg(15'h4000);
	check_ppu(14'h0400);
	cfg_write(3'd7, 8'h87);                                // Lockout on, all writes on
	cfg_write(3'd1, 8'h55);
	cfg_write(3'd6, 8'h08);
	check_prg(15'h0000);
	check_prg(15'h6000);
	check_strobes(1'b1);
endtask

task automatic test_uxrom_cnrom();
	logic [7:0] d;
	apply_reset();
	cfg_write(3'd6, 8'h01);
	exp_mapper = 5'd1;
	d = 8'($random(seed));
	bus_write(15'h0000, 1'b0, d);
	exp_r1 = d;
	check_prg(15'h0000);
	check_prg(15'h4000);
	cfg_write(3'd6, 8'h02);
	exp_mapper = 5'd2;
	d = 8'($random(seed));
	bus_write(15'h0000, 1'b0, d);
	exp_r0 = d;
	check_ppu(14'h0c00);
	check_ppu(14'h1400);
endtask

task automatic test_axrom_mirror();
	logic [7:0] d;
	apply_reset();
	cfg_write(3'd6, 8'h08);
	exp_mapper = 5'd8;
	d = 8'($random(seed));
	bus_write(15'h0000, 1'b0, d);
	exp_r1[4:0] = d[4:0];
	exp_mirror = {1'b1, d[4]};                             // One-screen
	check_prg(15'h0000);
	check_prg(15'h6000);
	check_ppu(14'h2400);
	check_ppu(14'h2800);
	cfg_write(3'd7, 8'h00);
	exp_mirror = 2'd0;
	check_ppu(14'h2400);
	check_ppu(14'h2800);
	cfg_write(3'd7, 8'h08);
	exp_mirror = 2'd1;
	check_ppu(14'h2400);
	check_ppu(14'h2800);
endtask

task automatic test_mmc1();
	logic [7:0] d;
	apply_reset();
	cfg_write(3'd6, 8'h10);
	exp_mapper = 5'd16;
	mmc1_load(15'h0000, 5'h1e);                            // CHR 4K, PRG mode 3, V
	exp_r1[4:2] = 3'b111;
	exp_mirror = 2'd0;
	d = 8'($random(seed));
	mmc1_load(15'h6000, d[4:0]);
	exp_r4 = {3'b000, d[4:0]};
	check_prg(15'h0000);
	check_prg(15'h4000);
	mmc1_load(15'h0000, 5'h1b);                            // PRG mode 2, H
	exp_r1[4:2] = 3'b110;
	exp_mirror = 2'd1;
	check_prg(15'h0000);
	check_prg(15'h4000);
	check_ppu(14'h2800);
	bus_write(15'h0000, 1'b0, 8'h80);                      // Serial reset
	exp_r1[3:2] = 2'b11;
	check_prg(15'h0000);
	check_prg(15'h4000);
	d = 8'($random(seed));
	mmc1_load(15'h2000, d[4:0]);
	exp_r2 = {3'b000, d[4:0]};
	d = 8'($random(seed));
	mmc1_load(15'h4000, d[4:0]);
	exp_r3 = {3'b000, d[4:0]};
	check_ppu(14'h0400);
	check_ppu(14'h1800);
endtask

task automatic test_rmw_guard();
	apply_reset();
	cfg_write(3'd6, 8'h01);
	exp_mapper = 5'd1;
	@(posedge m2);
	#1;
	romsel = 1'b0;
	cpu_rw = 1'b0;
	cpu_addr = 15'h0000;
	cpu_data = 8'h05;
	@(posedge m2);
	#1;
	cpu_data = 8'h09;                                      // Second write, no read between
	@(posedge m2);
	#1;
	romsel = 1'b1;
	cpu_rw = 1'b1;
	repeat (3) @(posedge m2);
	exp_r1 = 8'h05;
	check_prg(15'h0000);
endtask

// ==== tb/cart_mapper_tb.sv ====
`default_nettype none

module cart_mapper_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Resets 6x5, 44 writes x4, 41 check cycles
	localparam int BUS_CYCLES = 247;
	localparam int PERIOD_NS = 4;

	logic m2;
	logic ppu_addr_in;
	logic romsel;
	logic cpu_rw;
	logic [14:0] cpu_addr;
	logic [7:0] cpu_data;
	logic ppu_rd;
	logic ppu_wr;
	logic [13:0] ppu_addr;
	wire logic [26:13] cpu_addr_out;
	wire logic flash_we;
	wire logic flash_oe;
	wire logic sram_ce;
	wire logic sram_we;
	wire logic sram_oe;
	wire logic [17:10] ppu_addr_out;
	wire logic ppu_rd_out;
	wire logic ppu_wr_out;
	wire logic ppu_ciram_a10;

	int seed = 32'h2381;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	// Shadow of what the tests wrote
	logic [12:0] exp_base;
	logic [4:0] exp_mask;
	logic [4:0] exp_chr_mask;
	logic [4:0] exp_mapper;
	logic [1:0] exp_mirror;
	logic [7:0] exp_r0;
	logic [7:0] exp_r1;
	logic [7:0] exp_r2;
	logic [7:0] exp_r3;
	logic [7:0] exp_r4;

	cart_mapper_top u_cart_mapper_top (.*);

	initial m2 = 1'b0;
	always #(PERIOD_NS / 2) m2 = ~m2;

	task automatic apply_reset();
		@(posedge m2);
		#1;
		ppu_addr_in = 1'b1;
		exp_base = '0;
		exp_mask = '0;
		exp_chr_mask = '0;
		exp_mapper = '0;
		exp_mirror = '0;
		exp_r0 = '0;
		exp_r1 = '0;
		exp_r2 = '0;
		exp_r3 = '0;
		exp_r4 = '0;
		repeat (4) @(posedge m2);
		#1;
		ppu_addr_in = 1'b0;
	endtask

	`include "cart_mapper_tasks.svh"

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("%s done, %0d errors", name, errors - errors_before);
	endtask

	initial
	begin
		#(BUS_CYCLES * PERIOD_NS * 2);
		$display("Timeout after %0d ns, tests did not finish", $time);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		int e;
		ppu_addr_in = 1'b1;                                  // Reset from time zero
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		ppu_rd = 1'b1;
		ppu_wr = 1'b1;
		ppu_addr = '0;
		e = errors;
		test_reset();
		finish_test("reset", e);
		e = errors;
		test_config();
		finish_test("config", e);
		e = errors;
		test_uxrom_cnrom();
		finish_test("uxrom_cnrom", e);
		e = errors;
		test_axrom_mirror();
		finish_test("axrom_mirror", e);
		e = errors;
		test_mmc1();
		finish_test("mmc1", e);
		e = errors;
		test_rmw_guard();
		finish_test("rmw_guard", e);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cart_mapper_assert.sv ====
`default_nettype none

module cart_mapper_assert (
	input wire logic m2,
	input wire logic romsel,
	input wire logic flash_we,
	input wire logic sram_ce,
	input wire logic [13:0] ppu_addr,
	input wire logic ppu_rd_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// Flash is never written outside ROM space
	flash_we_in_rom: assert property (@(posedge m2) romsel |-> flash_we)
		else $error("flash_we low while romsel high");

	// SRAM only in the $6000 window
	sram_ce_off_rom: assert property (@(posedge m2) !romsel |-> sram_ce)
		else $error("sram_ce low while romsel low");

	nametable_to_ciram: assert property (@(posedge m2) ppu_addr[13] |-> ppu_rd_out)
		else $error("ppu_rd_out low for a nametable address");

endmodule

bind cart_mapper_top cart_mapper_assert u_assert (.*);

`default_nettype wire

// ==== hw/cart_mapper_top.sv ====
`default_nettype none

module cart_mapper_top (
	input wire logic m2,
	input wire logic ppu_addr_in,                 // Board reset
	input wire logic romsel,
	input wire logic cpu_rw,
	input wire logic [14:0] cpu_addr,
	input wire logic [7:0] cpu_data,
	input wire logic ppu_rd,
	input wire logic ppu_wr,
	input wire logic [13:0] ppu_addr,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);
	import cart_pkg::*;

	cpu_bus_t cpu_bus;
	reg_write_t reg_wr;
	cart_cfg_t cfg;
	bank_regs_t banks;

	assign cpu_bus = '{romsel: romsel, rw: cpu_rw, addr: cpu_addr, data: cpu_data};

	cpu_write_decoder u_decoder (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.bus(cpu_bus),
		.cfg(cfg),                                // Mapper code and lockout
		.wr(reg_wr)
	);

	bank_register_file u_regs (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.wr(reg_wr),
		.cfg(cfg),
		.banks(banks)
	);

	address_mapper u_mapper (
		.bus(cpu_bus),
		.ppu_rd(ppu_rd),
		.ppu_wr(ppu_wr),
		.ppu_addr(ppu_addr),
		.cfg(cfg),
		.banks(banks),
		.cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we),
		.flash_oe(flash_oe),
		.sram_ce(sram_ce),
		.sram_we(sram_we),
		.sram_oe(sram_oe),
		.ppu_addr_out(ppu_addr_out),
		.ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out),
		.ppu_ciram_a10(ppu_ciram_a10)
	);

endmodule

`default_nettype wire

// ==== hw/address_mapper.sv ====
`default_nettype none

module address_mapper (
	input wire cart_pkg::cpu_bus_t bus,
	input wire logic ppu_rd,
	input wire logic ppu_wr,
	input wire logic [13:0] ppu_addr,
	input wire cart_pkg::cart_cfg_t cfg,
	input wire cart_pkg::bank_regs_t banks,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);
	import cart_pkg::*;

	logic [PRG_BANK_W-1:0] prg_bank;              // A18-A13
	logic [CHR_BANK_W-1:0] chr_bank;              // A17-A10
	logic [12:0] prg_masked;

	always_comb
	begin
		// Simple mappers first
		if (!cfg.mapper[3])
			prg_bank = {bus.addr[14] ? 5'b11111 : banks.r1[4:0], bus.addr[13]}; // Last bank fixed
		else
			prg_bank = {banks.r1[3:0], bus.addr[14:13]}; // 32 KiB bank
		chr_bank = {banks.r0[4:0], ppu_addr[12:10]}; // 8 KiB CHR

		if (cfg.mapper == MAP_MMC1)
		begin
			case (banks.r1[3:2])
				2'b10:
					if (bus.addr[14])
						prg_bank = {1'b0, banks.r4[3:0], bus.addr[13]};
					else
						prg_bank = {5'b00000, bus.addr[13]}; // First bank at $8000
				2'b11:
					if (bus.addr[14])
						prg_bank = {5'b01111, bus.addr[13]}; // Last bank at $C000
					else
						prg_bank = {1'b0, banks.r4[3:0], bus.addr[13]};
				default: prg_bank = {1'b0, banks.r4[3:1], bus.addr[14:13]}; // 32 KiB mode
			endcase
			if (!banks.r1[4])
				chr_bank = {1'b0, banks.r2[4:1], ppu_addr[12:10]}; // 8 KiB mode
			else if (ppu_addr[12])
				chr_bank = {1'b0, banks.r3[4:0], ppu_addr[11:10]}; // Upper 4 KiB
			else
				chr_bank = {1'b0, banks.r2[4:0], ppu_addr[11:10]}; // Lower 4 KiB
		end
	end

	// Mask clears bank bits, base fills the rest
	assign prg_masked = {8'b0, prg_bank[5:1] & ~cfg.cpu_mask};
	assign cpu_addr_out = !bus.romsel ?
		{cfg.cpu_base | prg_masked, prg_bank[0]} :
		{12'b0, cfg.sram_page};                   // SRAM page otherwise
	assign ppu_addr_out = {chr_bank[7:3] & ~cfg.chr_mask, chr_bank[2:0]};

	// Flash only in ROM space, writes need enable
	assign flash_we = bus.rw | bus.romsel | ~cfg.prg_write_enabled;
	assign flash_oe = ~bus.rw | bus.romsel;
	assign sram_ce = ~(bus.addr[14] & bus.addr[13] & bus.romsel & cfg.sram_enabled); // $6000-$7FFF
	assign sram_we = bus.rw;
	assign sram_oe = ~bus.rw;

	assign ppu_rd_out = ppu_rd | ppu_addr[13];    // Nametables go to CIRAM
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~cfg.chr_write_enabled;

	// V, H, then one-screen A or B
	assign ppu_ciram_a10 = !cfg.mirroring[1] ?
		(!cfg.mirroring[0] ? ppu_addr[10] : ppu_addr[11]) :
		cfg.mirroring[0];

endmodule

`default_nettype wire

// ==== hw/bank_register_file.sv ====
`default_nettype none

module bank_register_file (
	input wire logic m2,
	input wire logic ppu_addr_in,
	input wire cart_pkg::reg_write_t wr,
	output cart_pkg::cart_cfg_t cfg,
	output cart_pkg::bank_regs_t banks
);
	import cart_pkg::*;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cfg <= '0;                                // NROM, unlocked, writes off
			banks <= '0;
		end
		else if (wr.valid)
		begin
			case (wr.sel)
				SEL_BASE_HI: cfg.cpu_base[12:8] <= wr.data[4:0];
				SEL_BASE_LO: cfg.cpu_base[7:0] <= wr.data;
				SEL_PRG_MASK: cfg.cpu_mask <= wr.data[4:0];
				SEL_R0, SEL_R0_ONLY: banks.r0 <= wr.data;
				SEL_CHR_MASK: cfg.chr_mask <= wr.data[4:0];
				SEL_R1_SRAM:
				begin
					banks.r1[5:0] <= wr.data[7:2];
					cfg.sram_page <= wr.data[1:0];
				end
				SEL_MAPPER: cfg.mapper <= wr.data[4:0];  // Upper bits ignored
				SEL_CONTROL:
				begin
					cfg.lockout <= wr.data[7];
					cfg.mirroring <= wr.data[4:3];
					cfg.prg_write_enabled <= wr.data[2];
					cfg.chr_write_enabled <= wr.data[1];
					cfg.sram_enabled <= wr.data[0];
				end
				SEL_R1: banks.r1 <= wr.data;
				SEL_R1_MIRROR:
				begin
					banks.r1[4:0] <= wr.data[4:0];
					cfg.mirroring <= {1'b1, wr.data[4]};  // One-screen
				end
				SEL_MMC1_CTRL:
				begin
					if (wr.data[7])
					begin
						banks.r1[3:2] <= 2'b11;              // Reset write, mode 3 only
					end
					else
					begin
						banks.r1[4:2] <= wr.data[4:2];       // CHR mode, PRG mode
						cfg.mirroring <= wr.data[1:0];
					end
				end
				SEL_R2: banks.r2[4:0] <= wr.data[4:0];   // CHR bank 0
				SEL_R3: banks.r3[4:0] <= wr.data[4:0];   // CHR bank 1
				SEL_R4: banks.r4[4:0] <= wr.data[4:0];   // PRG bank
				default: banks.r0 <= banks.r0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_write_decoder.sv ====
`default_nettype none

module cpu_write_decoder (
	input wire logic m2,
	input wire logic ppu_addr_in,
	input wire cart_pkg::cpu_bus_t bus,
	input wire cart_pkg::cart_cfg_t cfg,
	output cart_pkg::reg_write_t wr
);
	import cart_pkg::*;

	logic wr_seen;                                // Last edge was a write
	logic acc_valid;                              // Accepted write pending decode
	cpu_bus_t acc_bus;                            // Bus captured at the write edge
	logic [5:0] shift;                            // MMC1 load register
	logic [5:0] shift_in;
	logic [5:0] shift_next;
	reg_write_t cmd;

	// RMW guard, one write per run of writes
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			wr_seen <= 1'b0;
			acc_valid <= 1'b0;
		end
		else
		begin
			acc_valid <= ~bus.rw & ~wr_seen;          // First write after a read
			wr_seen <= ~bus.rw;                       // Read edge rearms
		end
	end

	always_ff @(posedge m2)
	begin
		acc_bus <= bus;
	end

	always_comb
	begin
		shift_in = {acc_bus.data[0], shift[5:1]};   // LSB first
		shift_next = shift;
		cmd.valid = 1'b0;
		cmd.sel = SEL_BASE_HI;
		cmd.data = acc_bus.data;
		if (acc_valid)
		begin
			if (acc_bus.romsel)
			begin
				if (acc_bus.addr[14:12] == CFG_PAGE && !cfg.lockout)
				begin
					cmd.valid = 1'b1;
					case (acc_bus.addr[2:0])
						CFG_BASE_HI: cmd.sel = SEL_BASE_HI;
						CFG_BASE_LO: cmd.sel = SEL_BASE_LO;
						CFG_PRG_MASK: cmd.sel = SEL_PRG_MASK;
						CFG_R0: cmd.sel = SEL_R0;
						CFG_CHR_MASK: cmd.sel = SEL_CHR_MASK;
						CFG_R1_SRAM: cmd.sel = SEL_R1_SRAM;
						CFG_MAPPER: cmd.sel = SEL_MAPPER;
						default: cmd.sel = SEL_CONTROL;  // $5xx7
					endcase
				end
			end
			else
			begin
				case (cfg.mapper)
					MAP_UXROM:
					begin
						cmd.valid = 1'b1;
						cmd.sel = SEL_R1;
					end
					MAP_CNROM:
					begin
						cmd.valid = 1'b1;
						cmd.sel = SEL_R0_ONLY;
					end
					MAP_AXROM:
					begin
						cmd.valid = 1'b1;
						cmd.sel = SEL_R1_MIRROR;             // Bit 4 picks the screen
					end
					MAP_MMC1:
					begin
						if (acc_bus.data[7])
						begin
							shift_next = MMC1_EMPTY;          // Serial reset
							cmd.valid = 1'b1;
							cmd.sel = SEL_MMC1_CTRL;
							cmd.data = 8'h80;                 // Force PRG mode 3
						end
						else if (shift_in[0])
						begin
							shift_next = MMC1_EMPTY;          // Fifth bit in
							cmd.valid = 1'b1;
							case (acc_bus.addr[14:13])
								2'b00:
								begin
									cmd.sel = SEL_MMC1_CTRL;
									cmd.data = {3'b000, shift_in[5:1] ^ 5'b00010}; // MMC1 to local mirroring
								end
								2'b01: cmd.sel = SEL_R2;
								2'b10: cmd.sel = SEL_R3;
								default: cmd.sel = SEL_R4;
							endcase
							if (acc_bus.addr[14:13] != 2'b00)
								cmd.data = {3'b000, shift_in[5:1]};
						end
						else
						begin
							shift_next = shift_in;            // Keep collecting
						end
					end
					default: cmd.valid = 1'b0;         // NROM has no registers
				endcase
			end
		end
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			wr <= '0;
			shift <= MMC1_EMPTY;
		end
		else
		begin
			wr <= cmd;                                // Valid one cycle after accept
			shift <= shift_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	localparam int MAPPER_W = 5;                  // Mapper number width
	localparam int PRG_BANK_W = 6;                // PRG bank bits A18-A13
	localparam int CHR_BANK_W = 8;                // CHR bank bits A17-A10

	// Mapper codes, same numbering as the multi-mapper firmware
	localparam logic [MAPPER_W-1:0] MAP_NROM  = 5'd0;
	localparam logic [MAPPER_W-1:0] MAP_UXROM = 5'd1;
	localparam logic [MAPPER_W-1:0] MAP_CNROM = 5'd2;
	localparam logic [MAPPER_W-1:0] MAP_AXROM = 5'd8;
	localparam logic [MAPPER_W-1:0] MAP_MMC1  = 5'd16;

	localparam logic [2:0] CFG_PAGE = 3'd5;       // $5xxx window
	localparam logic [2:0] CFG_BASE_HI  = 3'd0;   // $5xx0
	localparam logic [2:0] CFG_BASE_LO  = 3'd1;   // $5xx1
	localparam logic [2:0] CFG_PRG_MASK = 3'd2;   // $5xx2
	localparam logic [2:0] CFG_R0       = 3'd3;   // $5xx3
	localparam logic [2:0] CFG_CHR_MASK = 3'd4;   // $5xx4
	localparam logic [2:0] CFG_R1_SRAM  = 3'd5;   // $5xx5
	localparam logic [2:0] CFG_MAPPER   = 3'd6;   // $5xx6
	localparam logic [2:0] CFG_CONTROL  = 3'd7;   // $5xx7

	localparam logic [5:0] MMC1_EMPTY = 6'b100000; // Marker bit only

	typedef enum logic [3:0] {
		SEL_BASE_HI,                              // A26-A22
		SEL_BASE_LO,                              // A21-A14
		SEL_PRG_MASK,
		SEL_R0,                                   // Direct r0 from $5xx3
		SEL_CHR_MASK,
		SEL_R1_SRAM,                              // r1[5:0] plus SRAM page
		SEL_MAPPER,
		SEL_CONTROL,                              // Lockout, mirroring, enables
		SEL_R1,                                   // UxROM bank
		SEL_R0_ONLY,                              // CNROM bank
		SEL_MMC1_CTRL,                            // MMC1 control and mirroring
		SEL_R2,
		SEL_R3,
		SEL_R4,
		SEL_R1_MIRROR                             // AxROM bank, one-screen
	} reg_sel_e;

	typedef struct packed {
		logic valid;                              // One-cycle strobe
		reg_sel_e sel;
		logic [7:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [12:0] cpu_base;                    // A26-A14
		logic [4:0] cpu_mask;                     // Clears A18-A14
		logic [4:0] chr_mask;                     // Clears A17-A13
		logic [1:0] sram_page;
		logic [MAPPER_W-1:0] mapper;
		logic [1:0] mirroring;                    // V, H, 1Sa, 1Sb
		logic sram_enabled;
		logic prg_write_enabled;
		logic chr_write_enabled;
		logic lockout;
	} cart_cfg_t;

	typedef struct packed {
		logic [7:0] r0;
		logic [7:0] r1;
		logic [7:0] r2;
		logic [7:0] r3;
		logic [7:0] r4;
	} bank_regs_t;

	typedef struct packed {
		logic romsel;                             // Low for $8000-$FFFF
		logic rw;                                 // High on read
		logic [14:0] addr;
		logic [7:0] data;
	} cpu_bus_t;

endpackage

`default_nettype wire
